// ==== source/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// register file
`define REG_SIZE       8
`define REG_COUNT      16
`define REG_PTR_SIZE   4

// instruction store
`define INSN_SIZE      16
`define INSN_COUNT     16
`define INSN_PTR_SIZE  4
`define OPC_SIZE       4

// data address is {bank, byte}
`define CORE_ID_SIZE   2
`define ADDR_SIZE      10

// data memory latency in cycles before mem_ready
`define MEM_WAIT       2

`endif

// ==== source/isa_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package isa_pkg;

    // ADD to XOR write r[c] with r[a] op r[b]
    // CMPGE gives 1 or 0, shifts take r[b][2:0], MUL keeps the low byte
    // DIV by zero returns all ones
    // LD loads r[c] from mem[{r[b][1:0], r[a]}]
    // ST stores r[b] to mem[{r[c][1:0], r[a]}]
    // SET_CONST loads r[a] with {b, c}, or with the core id when a is 0
    // BNZ jumps to slot b when r[a] is not zero
    // READY ends the program, slot 15 always runs as READY
    typedef enum logic [`OPC_SIZE-1:0] {
        NOP       = 4'd0,
        READY     = 4'd1,
        ADD       = 4'd2,
        SUB       = 4'd3,
        MUL       = 4'd4,
        DIV       = 4'd5,
        CMPGE     = 4'd6,
        RSHIFT    = 4'd7,
        LSHIFT    = 4'd8,
        AND       = 4'd9,
        OR        = 4'd10,
        XOR       = 4'd11,
        LD        = 4'd12,
        SET_CONST = 4'd13,
        ST        = 4'd14,
        BNZ       = 4'd15
    } opcode_t;

    typedef logic [`REG_PTR_SIZE-1:0] reg_idx_t;

    typedef struct packed {
        opcode_t  opcode;   // 15:12
        reg_idx_t a;        // 11:8
        reg_idx_t b;        // 7:4, also branch target
        reg_idx_t c;        // 3:0
    } insn_t;

endpackage

`default_nettype wire

// ==== source/mem_pkg.sv ====
`default_nettype none

`include "core_params.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_t;

    // bank in the top bits, byte in the low eight
    typedef logic [`ADDR_SIZE-1:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== source/insn_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module insn_memory
    import isa_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          load,
    input  wire insn_t [`INSN_COUNT-1:0] insn_data,
    input  wire [`INSN_PTR_SIZE-1:0]     insn_ptr,
    output insn_t                        insn
);

    insn_t [`INSN_COUNT-1:0] words;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            words <= '0;  // NOP encodes as zero
        end
        else if (load)
        begin
            words <= insn_data;  // whole program at once
        end
    end

    assign insn = words[insn_ptr];

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module register_file
    import isa_pkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  clear,
    input  wire                  init_r0,
    input  wire [`REG_SIZE-1:0]  init_r0_data,
    input  wire reg_idx_t        rd_idx_a,
    input  wire reg_idx_t        rd_idx_b,
    input  wire reg_idx_t        rd_idx_c,
    output logic [`REG_SIZE-1:0] rd_data_a,
    output logic [`REG_SIZE-1:0] rd_data_b,
    output logic [`REG_SIZE-1:0] rd_data_c,
    input  wire                  wr_en,
    input  wire reg_idx_t        wr_idx,
    input  wire [`REG_SIZE-1:0]  wr_data
);

    logic [`REG_SIZE-1:0] regs [`REG_COUNT];

    // write-through so decode sees the value retiring this cycle
    function automatic logic [`REG_SIZE-1:0] read_port(reg_idx_t idx);
        if (wr_en && wr_idx == idx)
            return wr_data;
        return regs[idx];
    endfunction

    always_comb
    begin
        rd_data_a = read_port(rd_idx_a);
        rd_data_b = read_port(rd_idx_b);
        rd_data_c = read_port(rd_idx_c);
    end

    always_ff @(posedge clk)
    begin
        if (reset || clear)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
            if (!reset && init_r0)
                regs[0] <= init_r0_data;  // host preset of r0
        end
        else if (wr_en)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module alu
    import isa_pkg::*;
(
    input  wire opcode_t         opcode,
    input  wire [`REG_SIZE-1:0]  src_a,
    input  wire [`REG_SIZE-1:0]  src_b,
    output logic [`REG_SIZE-1:0] result,
    output logic                 branch_taken
);

    always_comb
    begin
        case (opcode)
            ADD:     result = src_a + src_b;
            SUB:     result = src_a - src_b;
            MUL:     result = src_a * src_b;  // low byte only
            DIV:
            begin
                if (src_b == '0)
                    result = '1;
                else
                    result = src_a / src_b;
            end
            CMPGE:   result = (src_a >= src_b) ? `REG_SIZE'(1) : '0;  // unsigned
            RSHIFT:  result = src_a >> src_b[2:0];
            LSHIFT:  result = src_a << src_b[2:0];
            AND:     result = src_a & src_b;
            OR:      result = src_a | src_b;
            XOR:     result = src_a ^ src_b;
            default: result = '0;
        endcase
    end

    assign branch_taken = (opcode == BNZ) && (src_a != '0);

endmodule

`default_nettype wire

// ==== source/core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module core
    import isa_pkg::*;
    import mem_pkg::*;
#(
    parameter int CORE_ID = 0
)(
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          start,
    output logic                         ready,
    input  wire                          init_r0_flag,
    input  wire [`REG_SIZE-1:0]          init_r0_data,
    input  wire insn_t [`INSN_COUNT-1:0] insn_data,
    output mem_op_t                      mem_op,
    output mem_addr_t                    mem_addr,
    output logic [`REG_SIZE-1:0]         wr_data,
    input  wire [`REG_SIZE-1:0]          rd_data,
    input  wire                          mem_ready
);

    localparam logic [`REG_SIZE-1:0] CORE_ID_WORD = `REG_SIZE'(CORE_ID);
    localparam insn_t NOP_INSN   = '{opcode: NOP, a: '0, b: '0, c: '0};
    localparam insn_t READY_INSN = '{opcode: READY, a: '0, b: '0, c: '0};

    function automatic logic is_alu_op(opcode_t op);
        return op inside {ADD, SUB, MUL, DIV, CMPGE, RSHIFT, LSHIFT, AND, OR, XOR};
    endfunction

    function automatic logic writes_reg(insn_t insn);
        return is_alu_op(insn.opcode) || (insn.opcode inside {LD, SET_CONST});
    endfunction

    function automatic reg_idx_t dest_idx(insn_t insn);
        return (insn.opcode == SET_CONST) ? insn.a : insn.c;
    endfunction

    function automatic logic reads_idx(insn_t insn, reg_idx_t idx);
        logic use_a;
        logic use_b;
        logic use_c;
        use_a = is_alu_op(insn.opcode) || (insn.opcode inside {LD, ST, BNZ});
        use_b = is_alu_op(insn.opcode) || (insn.opcode inside {LD, ST});
        use_c = (insn.opcode == ST);
        return (use_a && insn.a == idx) || (use_b && insn.b == idx) ||
               (use_c && insn.c == idx);
    endfunction

    function automatic logic raw_hazard(insn_t rd_insn, insn_t wr_insn);
        return writes_reg(wr_insn) && reads_idx(rd_insn, dest_idx(wr_insn));
    endfunction

    logic [`INSN_PTR_SIZE-1:0] pc;
    insn_t                     fd_insn;
    insn_t                     dx_insn;
    insn_t                     xm_insn;
    insn_t                     mw_insn;
    logic [`REG_SIZE-1:0]      dx_a;
    logic [`REG_SIZE-1:0]      dx_b;
    logic [`REG_SIZE-1:0]      dx_c;
    logic [`REG_SIZE-1:0]      xm_alu;
    logic [`REG_SIZE-1:0]      xm_store;
    mem_addr_t                 xm_addr;
    logic [`REG_SIZE-1:0]      mw_alu;
    logic [`REG_SIZE-1:0]      mw_load;

    insn_t                     mem_insn;
    insn_t                     fetch_insn;
    logic [`REG_SIZE-1:0]      rf_a;
    logic [`REG_SIZE-1:0]      rf_b;
    logic [`REG_SIZE-1:0]      rf_c;
    logic [`REG_SIZE-1:0]      alu_result;
    logic [`REG_SIZE-1:0]      wb_data;
    logic [`CORE_ID_SIZE-1:0]  ex_bank;
    logic                      branch_taken;
    logic                      start_accept;
    logic                      mem_busy;
    logic                      freeze;
    logic                      draining;
    logic                      hazard;
    logic                      wb_en;

    assign start_accept = start && ready;
    assign mem_busy     = (xm_insn.opcode inside {LD, ST}) && !mem_ready;
    assign freeze       = ready || mem_busy;
    assign hazard       = raw_hazard(fd_insn, dx_insn) || raw_hazard(fd_insn, xm_insn) ||
                          raw_hazard(fd_insn, mw_insn);

    // nothing behind a READY may take effect
    assign draining = (fd_insn.opcode == READY) || (dx_insn.opcode == READY) ||
                      (xm_insn.opcode == READY) || (mw_insn.opcode == READY);

    always_comb
    begin
        if (draining)
            fetch_insn = NOP_INSN;
        else if (pc == `INSN_PTR_SIZE'(`INSN_COUNT - 1))
            fetch_insn = READY_INSN;  // last slot always ends the run
        else
            fetch_insn = mem_insn;
    end

    insn_memory insn_memory_i (
        .clk       (clk),
        .reset     (reset),
        .load      (start_accept),
        .insn_data (insn_data),
        .insn_ptr  (pc),
        .insn      (mem_insn)
    );

    register_file register_file_i (
        .clk          (clk),
        .reset        (reset),
        .clear        (start_accept),
        .init_r0      (init_r0_flag),
        .init_r0_data (init_r0_data),
        .rd_idx_a     (fd_insn.a),
        .rd_idx_b     (fd_insn.b),
        .rd_idx_c     (fd_insn.c),
        .rd_data_a    (rf_a),
        .rd_data_b    (rf_b),
        .rd_data_c    (rf_c),
        .wr_en        (wb_en),
        .wr_idx       (dest_idx(mw_insn)),
        .wr_data      (wb_data)
    );

    alu alu_i (
        .opcode       (dx_insn.opcode),
        .src_a        (dx_a),
        .src_b        (dx_b),
        .result       (alu_result),
        .branch_taken (branch_taken)
    );

    assign ex_bank = (dx_insn.opcode == ST) ? dx_c[`CORE_ID_SIZE-1:0] : dx_b[`CORE_ID_SIZE-1:0];

    always_ff @(posedge clk)
    begin
        if (reset || start_accept)
        begin
            pc      <= '0;
            fd_insn <= NOP_INSN;
            dx_insn <= NOP_INSN;
            xm_insn <= NOP_INSN;
            mw_insn <= NOP_INSN;
        end
        else if (!freeze)
        begin
            if (branch_taken)
            begin
                pc      <= dx_insn.b;
                fd_insn <= NOP_INSN;  // flush slot in fetch
            end
            else if (!hazard)
            begin
                pc      <= pc + 1'b1;
                fd_insn <= fetch_insn;
            end
            dx_insn <= (branch_taken || hazard) ? NOP_INSN : fd_insn;  // bubble
            xm_insn <= dx_insn;
            mw_insn <= xm_insn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!freeze)
        begin
            dx_a     <= rf_a;
            dx_b     <= rf_b;
            dx_c     <= rf_c;
            xm_alu   <= alu_result;
            xm_addr  <= {ex_bank, dx_a};
            xm_store <= dx_b;
            mw_alu   <= xm_alu;
            mw_load  <= rd_data;  // valid on the mem_ready cycle of a load
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            ready <= 1'b1;
        else if (start_accept)
            ready <= 1'b0;
        else if (!ready && mw_insn.opcode == READY)
            ready <= 1'b1;
    end

    always_comb
    begin
        case (mw_insn.opcode)
            LD:        wb_data = mw_load;
            SET_CONST: wb_data = (mw_insn.a == '0) ? CORE_ID_WORD : {mw_insn.b, mw_insn.c};
            default:   wb_data = mw_alu;
        endcase
    end

    assign wb_en = writes_reg(mw_insn) && !freeze;

    always_comb
    begin
        case (xm_insn.opcode)
            LD:      mem_op = MEM_LOAD;
            ST:      mem_op = MEM_STORE;
            default: mem_op = MEM_IDLE;
        endcase
    end

    assign mem_addr = xm_addr;
    assign wr_data  = xm_store;

endmodule

`default_nettype wire

// ==== source/data_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module data_memory
    import mem_pkg::*;
#(
    parameter int WAIT = `MEM_WAIT
)(
    input  wire                  clk,
    input  wire                  reset,
    input  wire mem_op_t         mem_op,
    input  wire mem_addr_t       mem_addr,
    input  wire [`REG_SIZE-1:0]  wr_data,
    output logic [`REG_SIZE-1:0] rd_data,
    output logic                 mem_ready,
    input  wire mem_addr_t       host_addr,
    output logic [`REG_SIZE-1:0] host_rd_data
);

    localparam int DEPTH = 1 << `ADDR_SIZE;
    localparam int CNT_W = $clog2(WAIT + 2);

    logic [`REG_SIZE-1:0] mem [DEPTH];
    logic [CNT_W-1:0]     wait_cnt;

    // answer after WAIT cycles of a held request
    assign mem_ready = (mem_op != MEM_IDLE) && (wait_cnt == CNT_W'(WAIT));

    always_ff @(posedge clk)
    begin
        if (reset || mem_op == MEM_IDLE || mem_ready)
            wait_cnt <= '0;  // restart for a back-to-back request
        else
            wait_cnt <= wait_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= '0;
        end
        else if (mem_ready && mem_op == MEM_STORE)
        begin
            mem[mem_addr] <= wr_data;
        end
    end

    assign rd_data      = mem[mem_addr];
    assign host_rd_data = mem[host_addr];  // host reads while core idle

endmodule

`default_nettype wire

// ==== source/cluster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module cluster_top
    import isa_pkg::*;
    import mem_pkg::*;
(
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          start,
    output logic                         ready,
    input  wire                          init_r0_flag,
    input  wire [`REG_SIZE-1:0]          init_r0_data,
    input  wire insn_t [`INSN_COUNT-1:0] insn_data,
    input  wire mem_addr_t               host_addr,
    output logic [`REG_SIZE-1:0]         host_rd_data
);

    mem_op_t              mem_op;
    mem_addr_t            mem_addr;
    logic [`REG_SIZE-1:0] wr_data;
    logic [`REG_SIZE-1:0] rd_data;
    logic                 mem_ready;

    core #(
        .CORE_ID (1)
    ) core_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .ready        (ready),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .insn_data    (insn_data),
        .mem_op       (mem_op),
        .mem_addr     (mem_addr),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .mem_ready    (mem_ready)
    );

    data_memory #(
        .WAIT (`MEM_WAIT)
    ) data_memory_i (
        .clk          (clk),
        .reset        (reset),
        .mem_op       (mem_op),
        .mem_addr     (mem_addr),
        .wr_data      (wr_data),
        .rd_data      (rd_data),
        .mem_ready    (mem_ready),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data)
    );

endmodule

`default_nettype wire

// ==== dv/cluster_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module cluster_props
    import mem_pkg::*;
(
    input wire            clk,
    input wire            reset,
    input wire            start,
    input wire            ready,
    input wire mem_op_t   mem_op,
    input wire mem_addr_t mem_addr,
    input wire            mem_ready
);

    int failures = 0;  // failed assertions so far

    // request held until the memory answers
    assert property (@(posedge clk) disable iff (reset)
        (mem_op != MEM_IDLE && !mem_ready) |=> ($stable(mem_op) && $stable(mem_addr)))
        else
        begin
            failures++;
            $error("memory request changed before mem_ready");
        end

    // answer only for a request present through the wait states
    assert property (@(posedge clk) disable iff (reset)
        mem_ready |-> $past(mem_op != MEM_IDLE, `MEM_WAIT))
        else
        begin
            failures++;
            $error("mem_ready came before the wait states of a request");
        end

    assert property (@(posedge clk) disable iff (reset)
        (start && ready) |=> !ready)
        else
        begin
            failures++;
            $error("ready stayed high after an accepted start");
        end

endmodule

// the core ports carry both the handshake and the host control
bind core cluster_props props_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .ready     (ready),
    .mem_op    (mem_op),
    .mem_addr  (mem_addr),
    .mem_ready (mem_ready)
);

`default_nettype wire

// ==== dv/cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_params.svh"

module cluster_tb
    import isa_pkg::*;
    import mem_pkg::*;
;

    typedef insn_t [`INSN_COUNT-1:0] program_t;

    localparam int N_PROGS        = 7;
    localparam int TIMEOUT_CYCLES = N_PROGS * `INSN_COUNT * (5 + `MEM_WAIT + 1) * 4;
    localparam logic [`REG_SIZE-1:0] CORE_ID = 8'd1;  // as instanced in cluster_top

    logic                 clk;
    logic                 reset;
    logic                 start;
    logic                 ready;
    logic                 init_r0_flag;
    logic [`REG_SIZE-1:0] init_r0_data;
    program_t             insn_data;
    mem_addr_t            host_addr;
    logic [`REG_SIZE-1:0] host_rd_data;

    integer               seed = 86;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycle_count = 0;
    logic                 compare_req = 1'b0;
    insn_t                build_q [$];
    mem_addr_t            store_q [$];
    logic [`REG_SIZE-1:0] model_mem [1 << `ADDR_SIZE];
    program_t             prog;
    program_t             branch_prog;
    logic [`REG_SIZE-1:0] x;
    logic [`REG_SIZE-1:0] y;

    cluster_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .ready        (ready),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .insn_data    (insn_data),
        .host_addr    (host_addr),
        .host_rd_data (host_rd_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic emit(input opcode_t op, input int a, input int b, input int c);
        insn_t word;
        word.opcode = op;
        word.a      = reg_idx_t'(a);
        word.b      = reg_idx_t'(b);
        word.c      = reg_idx_t'(c);
        build_q.push_back(word);
    endtask

    task automatic emit_const(input int r, input logic [7:0] value);
        emit(SET_CONST, r, value[7:4], value[3:0]);
    endtask

    // result goes through r3 to a bank 0 byte since r15 stays zero
    task automatic emit_op_store(input opcode_t op, input int a, input int b,
                                 input logic [7:0] addr);
        emit(op, a, b, 3);
        emit_const(10, addr);
        emit(ST, 10, 3, 15);
    endtask

    function automatic program_t pack_program();
        program_t p;
        p = '0;  // unused slots stay NOP
        for (int k = 0; k < build_q.size(); k++)
            p[k] = build_q[k];
        build_q.delete();
        return p;
    endfunction

    // sequential interpretation of the ISA
    function automatic void run_model(input program_t p, input logic flag,
                                      input logic [7:0] r0v);
        logic [7:0] r [16];
        logic [7:0] va;
        logic [7:0] vb;
        mem_addr_t  addr;
        insn_t      ins;
        int         pc;
        int         steps;
        bit         done;
        foreach (r[k])
            r[k] = 8'h00;
        if (flag)
            r[0] = r0v;
        store_q.delete();
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 256)
        begin
            ins = p[pc];
            if (pc == `INSN_COUNT - 1)
                ins.opcode = READY;  // last slot
            va = r[ins.a];
            vb = r[ins.b];
            pc++;
            steps++;
            case (ins.opcode)
                ADD:       r[ins.c] = va + vb;
                SUB:       r[ins.c] = va - vb;
                MUL:       r[ins.c] = va * vb;
                DIV:       r[ins.c] = (vb == 8'h00) ? 8'hff : va / vb;
                CMPGE:     r[ins.c] = (va >= vb) ? 8'd1 : 8'd0;
                RSHIFT:    r[ins.c] = va >> vb[2:0];
                LSHIFT:    r[ins.c] = va << vb[2:0];
                AND:       r[ins.c] = va & vb;
                OR:        r[ins.c] = va | vb;
                XOR:       r[ins.c] = va ^ vb;
                LD:        r[ins.c] = model_mem[{vb[1:0], va}];
                SET_CONST: r[ins.a] = (ins.a == 4'd0) ? CORE_ID : {ins.b, ins.c};
                ST:
                begin
                    addr = {r[ins.c][1:0], va};
                    model_mem[addr] = vb;
                    store_q.push_back(addr);
                end
                BNZ:
                begin
                    if (va != 8'h00)
                        pc = ins.b;
                end
                READY:     done = 1'b1;
                default:   ;
            endcase
        end
    endfunction

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("Error at %0t: %s expected %02h, got %02h", $time, name, expected, actual);
        end
    endtask

    task automatic run_program(input program_t p, input logic flag, input logic [7:0] r0v);
        run_model(p, flag, r0v);
        @(posedge clk);
        insn_data    <= p;
        init_r0_flag <= flag;
        init_r0_data <= r0v;
        start        <= 1'b1;
        @(posedge clk);
        start <= 1'b0;  // taken on this edge
        @(negedge clk);
        while (!ready)
            @(negedge clk);
        compare_req = 1'b1;
        wait (!compare_req);
    endtask

    // reads back every address the model stored to
    initial
    begin
        forever
        begin
            wait (compare_req);
            foreach (store_q[k])
            begin
                @(posedge clk);
                host_addr <= store_q[k];
                @(negedge clk);
                check_value($sformatf("host_rd_data[%03h]", store_q[k]),
                            model_mem[store_q[k]], host_rd_data);
            end
            compare_req = 1'b0;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the core did not return to ready", cycle_count);
            $display("sim failed");
            $finish;
        end
    end

    initial
    begin
        reset        = 1'b1;
        start        = 1'b0;
        init_r0_flag = 1'b0;
        init_r0_data = '0;
        insn_data    = '0;
        host_addr    = '0;
        foreach (model_mem[k])
            model_mem[k] = 8'h00;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // every ALU operation stored to bank 0
        x = $random(seed);
        y = $random(seed);
        emit_const(1, x);
        emit_const(2, y);
        emit_op_store(ADD, 1, 2, 8'h10);
        emit_op_store(SUB, 1, 2, 8'h11);
        emit_op_store(MUL, 1, 2, 8'h12);
        emit_op_store(DIV, 1, 2, 8'h13);
        emit(READY, 0, 0, 0);
        prog = pack_program();
        run_program(prog, 1'b0, 8'h00);

        x = $random(seed);
        y = $random(seed);
        emit_const(1, x);
        emit_const(2, y);
        emit_op_store(CMPGE, 1, 2, 8'h14);
        emit_op_store(RSHIFT, 1, 2, 8'h15);
        emit_op_store(LSHIFT, 1, 2, 8'h16);
        emit_op_store(AND, 1, 2, 8'h17);
        emit(READY, 0, 0, 0);
        prog = pack_program();
        run_program(prog, 1'b0, 8'h00);

        x = $random(seed);
        y = $random(seed);
        emit_const(1, x);
        emit_const(2, y);
        emit_op_store(OR, 1, 2, 8'h18);
        emit_op_store(XOR, 1, 2, 8'h19);
        emit_op_store(DIV, 1, 15, 8'h1a);  // divisor zero
        emit_op_store(ADD, 3, 1, 8'h1b);
        emit(READY, 0, 0, 0);
        prog = pack_program();
        run_program(prog, 1'b0, 8'h00);

        // dependent chain on a preset r0 then r0 loaded with the core id
        x = $random(seed);
        y = $random(seed);
        emit_const(1, x);
        emit(ADD, 1, 1, 2);
        emit(SUB, 2, 0, 3);
        emit(MUL, 3, 2, 4);
        emit(XOR, 4, 3, 5);
        emit_const(10, 8'h20);
        emit(ST, 10, 5, 15);
        emit_const(10, 8'h21);
        emit(ST, 10, 4, 15);
        emit_const(0, 8'h00);
        emit_const(11, 8'h22);
        emit(ST, 11, 0, 15);
        emit(READY, 0, 0, 0);
        prog = pack_program();
        run_program(prog, 1'b1, y);

        // countdown loop where slots 5 and 6 count their own retirements
        x = 8'd3 + ({$random(seed)} % 4);
        emit_const(1, x);
        emit_const(2, 8'h01);
        emit(ADD, 3, 1, 3);
        emit(SUB, 1, 2, 1);
        emit(BNZ, 1, 2, 0);
        emit(ADD, 5, 2, 5);
        emit(ADD, 5, 2, 5);
        emit_const(10, 8'h30);
        emit(ST, 10, 1, 15);
        emit_const(10, 8'h31);
        emit(ST, 10, 3, 15);
        emit_const(10, 8'h32);
        emit(ST, 10, 5, 15);
        emit(READY, 0, 0, 0);
        branch_prog = pack_program();
        run_program(branch_prog, 1'b0, 8'h00);

        // banked stores and loads without READY so slot 15 ends it
        x = $random(seed);
        y = $random(seed);
        emit_const(1, x);
        emit_const(2, 8'h02);
        emit_const(3, y);
        emit(ST, 3, 1, 2);
        emit(LD, 3, 2, 4);
        emit_const(5, 8'h03);
        emit(ST, 3, 4, 5);  // loaded byte stored again
        emit(ADD, 4, 1, 7);
        emit_const(8, 8'h01);
        emit(ST, 3, 7, 8);
        emit(LD, 3, 8, 9);
        emit(ST, 3, 9, 15);
        prog = pack_program();
        run_program(prog, 1'b0, 8'h00);

        // rerun after dirty registers
        run_program(branch_prog, 1'b0, 8'h00);

        errors = errors + dut_i.core_i.props_i.failures;
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/isa_pkg.sv
source/mem_pkg.sv
source/insn_memory.sv
source/register_file.sv
source/alu.sv
source/core.sv
source/data_memory.sv
source/cluster_top.sv
dv/cluster_props.sv
dv/cluster_tb.sv
